//--- src/snowball_defs.svh
`ifndef SNOWBALL_DEFS_SVH
`define SNOWBALL_DEFS_SVH

// ------------------
// array geometry
// ------------------
`define SNB_LINES 256 // lines and translation entries
`define SNB_IDX_W 8   // index bits per array

// ------------------
// address regions
// ------------------
`define SNB_REGION_HI  31
`define SNB_REGION_LO  30
`define SNB_REGION_DMA 2'b11 // everything else is memory

`endif

//--- src/snowball_pkg.sv
package snowball_pkg;

  // ------------------
  // widths with meaning
  // ------------------
  typedef logic [31:0] addr_t;     // cpu or bus address
  typedef logic [31:0] word_t;     // data word
  typedef logic [15:0] page_tag_t; // address bits 31:16
  typedef logic [7:0]  line_idx_t; // line or translation entry
  typedef logic [23:0] line_tag_t; // page tag then addr 15:8

  // bus sequencer states
  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_MEM,
    BUS_DMA_RD,
    BUS_DMA_WR
  } bus_state_t;

endpackage

//--- src/cpu_request_latch.sv
`timescale 1ns/1ps

module cpu_request_latch
  import snowball_pkg::*;
(
  input  logic      CPU_CLK,
  input  logic      RST_CPU,
  input  addr_t     cache_precycle_addr,
  input  logic      cache_precycle_enable,
  input  logic      cache_precycle_we,
  input  logic      cache_precycle_force_miss,
  input  word_t     cache_datao,
  input  logic      WE_TLB,
  input  logic      cache_inhibit,
  input  logic      busy,
  input  logic      miss_start,
  output logic      lookup_go,
  output addr_t     lookup_addr,
  output word_t     lookup_wdata,
  output logic      lookup_we,
  output logic      lookup_tlb_we,
  output logic      lookup_force_miss,
  output logic      rd_en,
  output line_idx_t rd_idx,
  output line_idx_t rd_tlb_idx
);

  logic  held_valid;
  addr_t held_addr;
  word_t held_wdata;
  logic  held_we;
  logic  held_tlb_we;
  logic  held_force_miss;
  logic  accept;
  logic  replay;

  // a waiting held request blocks new ones
  assign accept = (cache_precycle_enable || WE_TLB) && !cache_inhibit &&
                  !busy && !held_valid;
  assign replay = held_valid && !busy; // first cycle after busy falls

  assign rd_en      = accept || replay;
  assign rd_idx     = replay ? held_addr[7:0] : cache_precycle_addr[7:0];
  assign rd_tlb_idx = replay ? held_addr[15:8] : cache_precycle_addr[15:8];

  always_ff @(posedge CPU_CLK)
  begin
    if (RST_CPU)
    begin
      lookup_go  <= 1'b0;
      held_valid <= 1'b0;
    end
    else
    begin
      // collision with a starting miss goes to the hold slot
      lookup_go <= (accept && !miss_start) || replay;
      if (accept && miss_start)
        held_valid <= 1'b1;
      else if (replay)
        held_valid <= 1'b0;
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
    begin
      held_addr       <= cache_precycle_addr;
      held_wdata      <= cache_datao;
      held_we         <= cache_precycle_we;
      held_tlb_we     <= WE_TLB;
      held_force_miss <= cache_precycle_force_miss;
    end
    if (rd_en)
    begin
      lookup_addr       <= replay ? held_addr : cache_precycle_addr;
      lookup_wdata      <= replay ? held_wdata : cache_datao;
      lookup_we         <= replay ? held_we : cache_precycle_we;
      lookup_tlb_we     <= replay ? held_tlb_we : WE_TLB;
      lookup_force_miss <= replay ? held_force_miss : cache_precycle_force_miss;
    end
  end

  // busy comes back from the lookup stage
  a_go_not_busy: assert property (@(posedge CPU_CLK) disable iff (RST_CPU)
    lookup_go |-> !busy);

endmodule

//--- src/cache_lookup.sv
`timescale 1ns/1ps
`include "snowball_defs.svh"

module cache_lookup
  import snowball_pkg::*;
(
  input  logic      CPU_CLK,
  input  logic      RST_CPU,
  input  logic      rd_en,
  input  line_idx_t rd_idx,
  input  line_idx_t rd_tlb_idx,
  input  logic      lookup_go,
  input  addr_t     lookup_addr,
  input  word_t     lookup_wdata,
  input  logic      lookup_we,
  input  logic      lookup_tlb_we,
  input  logic      lookup_force_miss,
  input  logic      VMEM_ACT,
  input  logic      bus_done,
  input  word_t     bus_rdata,
  input  logic      fill_we,
  output word_t     cache_datai,
  output logic      cache_busy,
  output logic      MMU_FAULT,
  output logic      busy,
  output logic      miss_start,
  output logic      bus_req,
  output addr_t     bus_addr,
  output word_t     bus_wdata,
  output logic      bus_we,
  output logic      bus_cacheable
);

  // ------------------
  // arrays
  // ------------------
  word_t     data_mem [0:`SNB_LINES-1];
  line_tag_t tag_mem  [0:`SNB_LINES-1];
  page_tag_t tlb_ptag [0:`SNB_LINES-1];
  page_tag_t tlb_vtag [0:`SNB_LINES-1];
  logic [`SNB_LINES-1:0] line_valid;

  word_t     data_rd;
  line_tag_t tag_rd;
  logic      valid_rd;
  page_tag_t ptag_rd;
  page_tag_t vtag_rd;
  line_idx_t cur_idx;
  line_idx_t cur_tlb_idx;
  page_tag_t virt_tag;
  page_tag_t phys_tag;
  line_tag_t cur_tag;
  addr_t     phys_addr;
  logic      is_dma;
  logic      tlb_write;
  logic      lookup_req;
  logic      hit;
  logic      fault;
  logic      need_bus;
  logic      read_hit;
  logic      line_wt;
  line_idx_t miss_idx;
  line_tag_t miss_tag;
  logic      pend_rd;
  logic      busy_q;
  logic      wr_en;
  line_idx_t wr_idx;
  word_t     wr_data;
  line_tag_t wr_tag;

  // ------------------
  // decision
  // ------------------
  assign cur_idx     = lookup_addr[`SNB_IDX_W-1:0];
  assign cur_tlb_idx = lookup_addr[2*`SNB_IDX_W-1:`SNB_IDX_W];
  assign virt_tag    = lookup_addr[31:16];
  assign phys_tag    = VMEM_ACT ? ptag_rd : virt_tag;
  assign phys_addr   = {phys_tag, lookup_addr[15:0]};
  assign cur_tag     = {phys_tag, cur_tlb_idx};
  assign is_dma      = phys_addr[`SNB_REGION_HI:`SNB_REGION_LO] == `SNB_REGION_DMA;

  assign tlb_write  = lookup_go && lookup_tlb_we;
  assign lookup_req = lookup_go && !lookup_tlb_we;
  assign hit        = valid_rd && (tag_rd == cur_tag);
  assign fault      = lookup_req && VMEM_ACT && (vtag_rd != virt_tag);
  assign need_bus   = lookup_req && !fault &&
                      (!hit || lookup_we || lookup_force_miss || is_dma);
  assign read_hit   = lookup_req && !fault && !need_bus;
  assign line_wt    = need_bus && lookup_we && !is_dma; // write-through allocate

  assign miss_start    = need_bus;
  assign bus_req       = need_bus;
  assign bus_addr      = phys_addr;
  assign bus_wdata     = lookup_wdata;
  assign bus_we        = lookup_we;
  assign bus_cacheable = !is_dma;
  assign busy          = busy_q;
  assign cache_busy    = busy_q;

  // refill and write-through never overlap
  assign wr_en   = line_wt || fill_we;
  assign wr_idx  = fill_we ? miss_idx : cur_idx;
  assign wr_data = fill_we ? bus_rdata : lookup_wdata;
  assign wr_tag  = fill_we ? miss_tag : cur_tag;

  always_ff @(posedge CPU_CLK)
  begin
    if (rd_en)
    begin
      data_rd <= data_mem[rd_idx];
      tag_rd  <= tag_mem[rd_idx];
    end
    if (wr_en)
    begin
      data_mem[wr_idx] <= wr_data;
      tag_mem[wr_idx]  <= wr_tag;
    end
  end

  // translation entry written in this cycle is forwarded to a same-entry read
  always_ff @(posedge CPU_CLK)
  begin
    if (rd_en)
    begin
      if (tlb_write && (rd_tlb_idx == cur_tlb_idx))
      begin
        ptag_rd <= lookup_wdata[31:16];
        vtag_rd <= lookup_wdata[15:0];
      end
      else
      begin
        ptag_rd <= tlb_ptag[rd_tlb_idx];
        vtag_rd <= tlb_vtag[rd_tlb_idx];
      end
    end
    if (tlb_write)
    begin
      tlb_ptag[cur_tlb_idx] <= lookup_wdata[31:16]; // physical tag
      tlb_vtag[cur_tlb_idx] <= lookup_wdata[15:0];  // expected virtual tag
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (RST_CPU)
    begin
      line_valid <= '0;
      valid_rd   <= 1'b0;
    end
    else
    begin
      if (rd_en)
        valid_rd <= line_valid[rd_idx];
      if (wr_en)
        line_valid[wr_idx] <= 1'b1;
    end
  end

  // ------------------
  // busy and fault
  // ------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (RST_CPU)
    begin
      busy_q    <= 1'b0;
      MMU_FAULT <= 1'b0;
      pend_rd   <= 1'b0;
    end
    else
    begin
      MMU_FAULT <= fault;
      if (need_bus)
      begin
        busy_q  <= 1'b1;
        pend_rd <= !lookup_we;
      end
      else if (bus_done)
        busy_q <= 1'b0;
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (need_bus)
    begin
      miss_idx <= cur_idx; // refill target
      miss_tag <= cur_tag;
    end
    if (read_hit)
      cache_datai <= data_rd;
    else if (bus_done && pend_rd)
      cache_datai <= bus_rdata;
  end

  // a refill never meets a lookup on the shared write port
  a_fill_no_lookup: assert property (@(posedge CPU_CLK) disable iff (RST_CPU)
    fill_we |-> !lookup_go);

endmodule

//--- src/mem_bus_sequencer.sv
`timescale 1ns/1ps
`include "snowball_defs.svh"

module mem_bus_sequencer
  import snowball_pkg::*;
(
  input  logic  CPU_CLK,
  input  logic  RST_CPU,
  input  logic  bus_req,
  input  addr_t bus_addr,
  input  word_t bus_wdata,
  input  logic  bus_we,
  input  logic  bus_cacheable,
  input  logic  mem_ack,
  input  word_t mem_datafrommem,
  input  logic  dma_wrte_ack,
  input  logic  dma_read_ack,
  input  word_t dma_data_read,
  output addr_t mem_addr,
  output logic  mem_we,
  output logic  mem_do_act,
  output word_t mem_dataintomem,
  output logic  dma_wrte,
  output logic  dma_read,
  output logic  bus_done,
  output word_t bus_rdata,
  output logic  fill_we
);

  bus_state_t state;
  logic       start;
  logic       req_dma;
  logic       req_fill; // refill wanted on completion

  assign start   = (state == BUS_IDLE) && bus_req;
  assign req_dma = bus_addr[`SNB_REGION_HI:`SNB_REGION_LO] == `SNB_REGION_DMA;

  // ------------------
  // strobe fsm
  // ------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (RST_CPU)
    begin
      state      <= BUS_IDLE;
      mem_do_act <= 1'b0;
      mem_we     <= 1'b0;
      dma_read   <= 1'b0;
      dma_wrte   <= 1'b0;
      bus_done   <= 1'b0;
      fill_we    <= 1'b0;
    end
    else
    begin
      bus_done <= 1'b0;
      fill_we  <= 1'b0;
      case (state)
        BUS_IDLE:
          if (bus_req)
          begin
            if (req_dma && bus_we)
            begin
              dma_wrte <= 1'b1;
              state    <= BUS_DMA_WR;
            end
            else if (req_dma)
            begin
              dma_read <= 1'b1;
              state    <= BUS_DMA_RD;
            end
            else
            begin
              mem_do_act <= 1'b1;
              mem_we     <= bus_we; // level until ack
              state      <= BUS_MEM;
            end
          end
        BUS_MEM:
          if (mem_ack)
          begin
            mem_do_act <= 1'b0;
            mem_we     <= 1'b0;
            bus_done   <= 1'b1;
            fill_we    <= req_fill;
            state      <= BUS_IDLE;
          end
        BUS_DMA_RD:
          if (dma_read_ack)
          begin
            dma_read <= 1'b0;
            bus_done <= 1'b1;
            state    <= BUS_IDLE;
          end
        BUS_DMA_WR:
          if (dma_wrte_ack)
          begin
            dma_wrte <= 1'b0;
            bus_done <= 1'b1;
            state    <= BUS_IDLE;
          end
        default:
          state <= BUS_IDLE;
      endcase
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (start)
    begin
      mem_addr        <= bus_addr;
      mem_dataintomem <= bus_wdata; // dma writes use it too
      req_fill        <= bus_cacheable && !bus_we;
    end
    if ((state == BUS_MEM) && mem_ack)
      bus_rdata <= mem_datafrommem;
    else if ((state == BUS_DMA_RD) && dma_read_ack)
      bus_rdata <= dma_data_read;
  end

  a_one_strobe: assert property (@(posedge CPU_CLK) disable iff (RST_CPU)
    $onehot0({mem_do_act, dma_read, dma_wrte}));

  // lookup holds busy until the sequencer is idle again
  a_req_idle: assert property (@(posedge CPU_CLK) disable iff (RST_CPU)
    bus_req |-> state == BUS_IDLE);

endmodule

//--- src/snowball_cache.sv
`timescale 1ns/1ps

module snowball_cache
  import snowball_pkg::*;
(
  input  logic  CPU_CLK,
  input  logic  RST_CPU,
  // cpu side
  input  addr_t cache_precycle_addr,
  input  word_t cache_datao,
  output word_t cache_datai,
  input  logic  cache_precycle_we,
  output logic  cache_busy,
  input  logic  cache_precycle_enable,
  input  logic  cache_precycle_force_miss,
  // memory port
  output addr_t mem_addr,
  output logic  mem_we,
  output logic  mem_do_act,
  output word_t mem_dataintomem,
  input  logic  mem_ack,
  input  word_t mem_datafrommem,
  // dma port
  output logic  dma_wrte,
  output logic  dma_read,
  input  logic  dma_wrte_ack,
  input  logic  dma_read_ack,
  input  word_t dma_data_read,
  // control
  input  logic  VMEM_ACT,
  input  logic  cache_inhibit,
  output logic  MMU_FAULT,
  input  logic  WE_TLB
);

  logic      lookup_go;
  addr_t     lookup_addr;
  word_t     lookup_wdata;
  logic      lookup_we;
  logic      lookup_tlb_we;
  logic      lookup_force_miss;
  logic      rd_en;
  line_idx_t rd_idx;
  line_idx_t rd_tlb_idx;
  logic      busy;
  logic      miss_start;
  logic      bus_req;
  addr_t     bus_addr;
  word_t     bus_wdata;
  logic      bus_we;
  logic      bus_cacheable;
  logic      bus_done;
  word_t     bus_rdata;
  logic      fill_we;

  cpu_request_latch u_latch (
    .CPU_CLK, .RST_CPU,
    .cache_precycle_addr, .cache_precycle_enable, .cache_precycle_we,
    .cache_precycle_force_miss, .cache_datao, .WE_TLB, .cache_inhibit,
    .busy, .miss_start,
    .lookup_go, .lookup_addr, .lookup_wdata, .lookup_we, .lookup_tlb_we,
    .lookup_force_miss, .rd_en, .rd_idx, .rd_tlb_idx
  );

  cache_lookup u_lookup (
    .CPU_CLK, .RST_CPU,
    .rd_en, .rd_idx, .rd_tlb_idx,
    .lookup_go, .lookup_addr, .lookup_wdata, .lookup_we, .lookup_tlb_we,
    .lookup_force_miss, .VMEM_ACT, .bus_done, .bus_rdata, .fill_we,
    .cache_datai, .cache_busy, .MMU_FAULT, .busy, .miss_start,
    .bus_req, .bus_addr, .bus_wdata, .bus_we, .bus_cacheable
  );

  mem_bus_sequencer u_bus (
    .CPU_CLK, .RST_CPU,
    .bus_req, .bus_addr, .bus_wdata, .bus_we, .bus_cacheable,
    .mem_ack, .mem_datafrommem, .dma_wrte_ack, .dma_read_ack, .dma_data_read,
    .mem_addr, .mem_we, .mem_do_act, .mem_dataintomem,
    .dma_wrte, .dma_read, .bus_done, .bus_rdata, .fill_we
  );

endmodule

//--- bench/mem_dma_model.sv
`timescale 1ns/1ps

module mem_dma_model
  import snowball_pkg::*;
#(
  parameter word_t MEM_PAT = 32'h5A5A_0FF0,
  parameter word_t DMA_PAT = 32'h0101_1000
)
(
  input  logic  CPU_CLK,
  input  logic  RST_CPU,
  input  addr_t mem_addr,
  input  logic  mem_we,
  input  logic  mem_do_act,
  input  word_t mem_dataintomem,
  input  logic  dma_wrte,
  input  logic  dma_read,
  output logic  mem_ack,
  output word_t mem_datafrommem,
  output logic  dma_wrte_ack,
  output logic  dma_read_ack,
  output word_t dma_data_read,
  output addr_t last_wr_addr,
  output word_t last_wr_data
);

  int   delay;
  logic armed; // a strobe is being counted down

  // responses change on the falling edge
  always @(negedge CPU_CLK)
  begin
    if (RST_CPU)
    begin
      mem_ack         <= 1'b0;
      dma_wrte_ack    <= 1'b0;
      dma_read_ack    <= 1'b0;
      mem_datafrommem <= '0;
      dma_data_read   <= '0;
      last_wr_addr    <= '0;
      last_wr_data    <= '0;
      armed           <= 1'b0;
      delay           <= 0;
    end
    else if (mem_ack || dma_wrte_ack || dma_read_ack)
    begin
      mem_ack      <= 1'b0; // single cycle ack
      dma_wrte_ack <= 1'b0;
      dma_read_ack <= 1'b0;
      armed        <= 1'b0;
    end
    else if (mem_do_act || dma_read || dma_wrte)
    begin
      if (!armed)
      begin
        armed <= 1'b1;
        delay <= $urandom_range(1, 4);
      end
      else if (delay > 1)
        delay <= delay - 1;
      else
      begin
        mem_ack         <= mem_do_act;
        dma_read_ack    <= dma_read;
        dma_wrte_ack    <= dma_wrte;
        mem_datafrommem <= mem_addr ^ MEM_PAT; // dma port shares mem_addr
        dma_data_read   <= mem_addr + DMA_PAT;
        if (mem_we || dma_wrte)
        begin
          last_wr_addr <= mem_addr;
          last_wr_data <= mem_dataintomem;
        end
      end
    end
  end

endmodule

//--- bench/tb_snowball_cache.sv
`timescale 1ns/1ps

module tb_snowball_cache
  import snowball_pkg::*;
;

  localparam word_t MEM_PAT = 32'hA5A5_5A5A;
  localparam word_t DMA_PAT = 32'h1357_9BDF;

  logic  CPU_CLK = 1'b1;
  logic  RST_CPU;
  addr_t cache_precycle_addr;
  word_t cache_datao;
  word_t cache_datai;
  logic  cache_precycle_we;
  logic  cache_busy;
  logic  cache_precycle_enable;
  logic  cache_precycle_force_miss;
  addr_t mem_addr;
  logic  mem_we;
  logic  mem_do_act;
  word_t mem_dataintomem;
  logic  mem_ack;
  word_t mem_datafrommem;
  logic  dma_wrte;
  logic  dma_read;
  logic  dma_wrte_ack;
  logic  dma_read_ack;
  word_t dma_data_read;
  logic  VMEM_ACT;
  logic  cache_inhibit;
  logic  MMU_FAULT;
  logic  WE_TLB;
  addr_t last_wr_addr;
  word_t last_wr_data;

  // expectations for the access in flight
  addr_t exp_addr;
  word_t exp_wdata;
  logic  exp_we;
  logic  exp_bus;
  logic  exp_fault;
  int    check_errs = 0;
  int    assert_errs = 0;
  int    timeouts = 0;
  int    txn_cnt = 0;

  addr_t a;
  addr_t b;
  addr_t c;
  addr_t v;
  addr_t p;
  word_t d;
  word_t prev;

  snowball_cache DUT (.*);

  mem_dma_model #(.MEM_PAT(MEM_PAT), .DMA_PAT(DMA_PAT)) u_model (.*);

  always #5 CPU_CLK = ~CPU_CLK;

  always @(posedge CPU_CLK)
    if (mem_ack || dma_read_ack || dma_wrte_ack)
      txn_cnt <= txn_cnt + 1; // completed bus cycles

  // --------------------
  // bus and fault checks
  // --------------------
  a_mem_req: assert property (@(posedge CPU_CLK) disable iff (RST_CPU)
    $rose(mem_do_act) |-> mem_addr == exp_addr && mem_we == exp_we)
    else
    begin
      $display("CHECK FAILED mem_addr/mem_we got %h/%h expected %h/%h",
               $sampled(mem_addr), $sampled(mem_we), exp_addr, exp_we);
      assert_errs++;
    end

  a_wr_data: assert property (@(posedge CPU_CLK) disable iff (RST_CPU)
    $rose(mem_do_act || dma_wrte) && exp_we |-> mem_dataintomem == exp_wdata)
    else
    begin
      $display("CHECK FAILED mem_dataintomem got %h expected %h",
               $sampled(mem_dataintomem), exp_wdata);
      assert_errs++;
    end

  a_dma_req: assert property (@(posedge CPU_CLK) disable iff (RST_CPU)
    $rose(dma_read || dma_wrte) |-> mem_addr == exp_addr && dma_wrte == exp_we)
    else
    begin
      $display("CHECK FAILED dma mem_addr/dma_wrte got %h/%h expected %h/%h",
               $sampled(mem_addr), $sampled(dma_wrte), exp_addr, exp_we);
      assert_errs++;
    end

  a_no_stray_bus: assert property (@(posedge CPU_CLK) disable iff (RST_CPU)
    ($rose(mem_do_act || dma_read || dma_wrte) || cache_busy) |-> exp_bus)
    else
    begin
      $display("bus strobe or cache_busy seen on an access that needs no bus");
      assert_errs++;
    end

  a_fault: assert property (@(posedge CPU_CLK) disable iff (RST_CPU)
    MMU_FAULT |-> exp_fault && !cache_busy ##1 !MMU_FAULT)
    else
    begin
      $display("MMU_FAULT raised unexpectedly, with busy, or for more than one cycle");
      assert_errs++;
    end

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      check_errs++;
    end
  endtask

  function automatic addr_t rand_mem_addr();
    addr_t r;
    r = $urandom();
    r[31:30] = 2'($urandom_range(0, 2)); // regions 00, 01, 10
    return r;
  endfunction

  // starts and ends on a falling edge with busy low
  task automatic cpu_access(input addr_t addr, input logic we, input word_t wdata,
                            input logic force_miss, input addr_t phys,
                            input logic bus_expected);
    int start_txn;
    int waited;
    start_txn = txn_cnt;
    exp_addr  = phys;
    exp_we    = we;
    exp_wdata = wdata;
    exp_bus   = bus_expected;
    cache_precycle_addr       = addr;
    cache_precycle_we         = we;
    cache_datao               = wdata;
    cache_precycle_force_miss = force_miss;
    cache_precycle_enable     = 1'b1;
    @(negedge CPU_CLK);
    cache_precycle_enable     = 1'b0;
    cache_precycle_we         = 1'b0;
    cache_precycle_force_miss = 1'b0;
    @(negedge CPU_CLK);
    check_word("cache_busy", 32'(cache_busy), 32'(bus_expected));
    waited = 0;
    while (cache_busy && waited < 40)
    begin
      @(negedge CPU_CLK);
      waited++;
    end
    if (cache_busy)
    begin
      $display("timeout: cache_busy stayed high after access to %h", addr);
      timeouts++;
    end
    check_word("bus transactions", 32'(txn_cnt - start_txn), bus_expected ? 1 : 0);
  endtask

  task automatic tlb_write(input logic [7:0] entry, input page_tag_t ptag,
                           input page_tag_t vtag);
    exp_bus             = 1'b0;
    cache_precycle_addr = {16'h0000, entry, 8'h00};
    cache_datao         = {ptag, vtag};
    WE_TLB              = 1'b1;
    @(negedge CPU_CLK);
    WE_TLB = 1'b0;
    @(negedge CPU_CLK);
  endtask

  initial
  begin
    void'($urandom(89));
    RST_CPU = 1'b1;
    cache_precycle_addr = '0;
    cache_datao = '0;
    cache_precycle_we = 1'b0;
    cache_precycle_enable = 1'b0;
    cache_precycle_force_miss = 1'b0;
    VMEM_ACT = 1'b0;
    cache_inhibit = 1'b0;
    WE_TLB = 1'b0;
    exp_addr = '0;
    exp_wdata = '0;
    exp_we = 1'b0;
    exp_bus = 1'b0;
    exp_fault = 1'b0;
    repeat (5) @(posedge CPU_CLK);
    @(negedge CPU_CLK);
    RST_CPU = 1'b0;
    @(negedge CPU_CLK);

    // read miss
    a = rand_mem_addr();
    cpu_access(a, 1'b0, '0, 1'b0, a, 1'b1);
    check_word("cache_datai", cache_datai, a ^ MEM_PAT);

    // write-through to another line and read back
    b = rand_mem_addr();
    b[7:0] = ~a[7:0]; // keeps line a resident
    d = $urandom();
    cpu_access(b, 1'b1, d, 1'b0, b, 1'b1);
    check_word("last_wr_addr", last_wr_addr, b);
    check_word("last_wr_data", last_wr_data, d);
    cpu_access(b, 1'b0, '0, 1'b0, b, 1'b0);
    check_word("cache_datai", cache_datai, d);

    // repeat read of line a hits
    cpu_access(a, 1'b0, '0, 1'b0, a, 1'b0);
    check_word("cache_datai", cache_datai, a ^ MEM_PAT);

    // dma region writes and uncached reads
    c = $urandom();
    c[31:30] = 2'b11;
    d = $urandom();
    cpu_access(c, 1'b1, d, 1'b0, c, 1'b1);
    check_word("last_wr_addr", last_wr_addr, c);
    check_word("last_wr_data", last_wr_data, d);
    repeat (2)
    begin
      cpu_access(c, 1'b0, '0, 1'b0, c, 1'b1);
      check_word("cache_datai", cache_datai, c + DMA_PAT);
    end

    // forced miss on a cached line then inhibited requests
    cpu_access(a, 1'b0, '0, 1'b1, a, 1'b1);
    check_word("cache_datai", cache_datai, a ^ MEM_PAT);
    prev = cache_datai;
    cache_inhibit = 1'b1;
    cpu_access(b, 1'b0, '0, 1'b0, b, 1'b0);
    cpu_access(rand_mem_addr(), 1'b1, $urandom(), 1'b0, '0, 1'b0);
    check_word("cache_datai", cache_datai, prev);
    cache_inhibit = 1'b0;

    // translation hit and virtual tag mismatch
    tlb_write(8'h3C, 16'h2468, 16'h1357);
    VMEM_ACT = 1'b1;
    v = {16'h1357, 8'h3C, 8'($urandom())};
    p = {16'h2468, v[15:0]};
    cpu_access(v, 1'b0, '0, 1'b0, p, 1'b1);
    check_word("cache_datai", cache_datai, p ^ MEM_PAT);
    exp_fault = 1'b1;
    cpu_access({16'h1111, v[15:0]}, 1'b0, '0, 1'b0, p, 1'b0);
    check_word("MMU_FAULT", 32'(MMU_FAULT), 32'd1);
    @(negedge CPU_CLK);
    exp_fault = 1'b0;
    VMEM_ACT = 1'b0;
    repeat (3) @(negedge CPU_CLK);

    $display("errors: checks=%0d assertions=%0d timeouts=%0d",
             check_errs, assert_errs, timeouts);
    if (check_errs + assert_errs + timeouts == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- sources.f
+incdir+src
src/snowball_pkg.sv
src/cpu_request_latch.sv
src/cache_lookup.sv
src/mem_bus_sequencer.sv
src/snowball_cache.sv
bench/mem_dma_model.sv
bench/tb_snowball_cache.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
    --top-module tb_snowball_cache -Mdir obj_dir \
  && ./obj_dir/Vtb_snowball_cache | tee /dev/stderr \
    | grep -F '*** TEST PASSED ***' > /dev/null \
  && { echo "simulation ok"; exit 0; } \
  || { echo "simulation failed"; exit 1; }
